// ==== hw/sdmac_config.svh ====
// Build constants for the SCSI DMA register block
// FIFO depth must stay a power of two; register offsets are full 8-bit matches
`ifndef SDMAC_CONFIG_SVH
`define SDMAC_CONFIG_SVH

// Datapath
`define SDMAC_DATA_W      32         // Bus and FIFO word width
`define SDMAC_FIFO_DEPTH  8          // FIFO words, power of two

// Register offsets within the 8-bit address
`define SDMAC_REG_DAWR    8'h00      // Data ack width, writes ignored
`define SDMAC_REG_WTC     8'h04      // Word transfer count, reads zero
`define SDMAC_REG_CNTR    8'h08      // Control
`define SDMAC_REG_ACR     8'h0C      // Address counter, A1 only
`define SDMAC_REG_ST_DMA  8'h10      // Start DMA strobe
`define SDMAC_REG_FLUSH   8'h14      // Flush FIFO strobe
`define SDMAC_REG_CLR_INT 8'h18      // Clear interrupts strobe
`define SDMAC_REG_ISTR    8'h1C      // Interrupt status, read only
`define SDMAC_REG_SP_DMA  8'h3C      // Stop DMA strobe

// CNTR layout
`define SDMAC_CNTR_W      6          // Stored CNTR bits
`define SDMAC_CNTR_INTEN  2          // Interrupt enable bit

// ACR write data
`define SDMAC_ACR_A1_BIT  25         // Write-data bit kept as A1

`endif

// ==== hw/sdmac_pkg.sv ====
// Shared types for the register block
// ISTR upper bits are reserved and always read zero
package sdmac_pkg;

  // One value per decoded register or action address
  typedef enum logic [3:0] {
    SEL_NONE    = 4'd0,  // Unmapped address
    SEL_DAWR    = 4'd1,
    SEL_WTC     = 4'd2,
    SEL_CNTR    = 4'd3,
    SEL_ACR     = 4'd4,
    SEL_ST_DMA  = 4'd5,
    SEL_FLUSH   = 4'd6,
    SEL_CLR_INT = 4'd7,
    SEL_ISTR    = 4'd8,
    SEL_SP_DMA  = 4'd9
  } reg_sel_e;

  // ISTR as seen by the CPU, MSB first
  typedef struct packed {
    logic [3:0] rsvd;   // Bits 8..5, zero
    logic       int_p;  // Interrupt pending, E_INT and INTEN
    logic       ovr;    // Push while full, latched
    logic       e_int;  // Device interrupt, latched
    logic       ff;     // FIFO full, live
    logic       fe;     // FIFO empty, live
  } istr_t;

endpackage

// ==== hw/sdmac_addr_decoder.sv ====
// Combinational decode of a single-cycle bus strobe
// At most one write or action strobe per access; reads report a select instead
`timescale 1ns/10ps
`include "sdmac_config.svh"

module sdmac_addr_decoder (
  input  logic                bus_stb,    // Access valid this cycle
  input  logic                bus_rw,     // 1 = read
  input  logic [7:0]          bus_addr,
  output logic                rd_stb,
  output sdmac_pkg::reg_sel_e rd_sel,
  output logic                cntr_wr,
  output logic                acr_wr,
  output logic                st_dma,
  output logic                sp_dma,
  output logic                flush_req,
  output logic                clr_int
);

  import sdmac_pkg::*;

  reg_sel_e sel;  // Address match, ignores strobe
  logic     wr;   // Qualified write

  // Full address compare only, no aliasing
  always_comb begin
    case (bus_addr)
      `SDMAC_REG_DAWR:    sel = SEL_DAWR;
      `SDMAC_REG_WTC:     sel = SEL_WTC;
      `SDMAC_REG_CNTR:    sel = SEL_CNTR;
      `SDMAC_REG_ACR:     sel = SEL_ACR;
      `SDMAC_REG_ST_DMA:  sel = SEL_ST_DMA;
      `SDMAC_REG_FLUSH:   sel = SEL_FLUSH;
      `SDMAC_REG_CLR_INT: sel = SEL_CLR_INT;
      `SDMAC_REG_ISTR:    sel = SEL_ISTR;
      `SDMAC_REG_SP_DMA:  sel = SEL_SP_DMA;
      default:            sel = SEL_NONE;
    endcase
  end

  assign wr     = bus_stb & ~bus_rw;
  assign rd_stb = bus_stb & bus_rw;      // Every read gets rvalid, mapped or not
  assign rd_sel = rd_stb ? sel : SEL_NONE;

  // Write strobes; DAWR, ISTR and unmapped writes raise nothing
  assign cntr_wr   = wr & (sel == SEL_CNTR);
  assign acr_wr    = wr & (sel == SEL_ACR);
  assign st_dma    = wr & (sel == SEL_ST_DMA);
  assign sp_dma    = wr & (sel == SEL_SP_DMA);
  assign flush_req = wr & (sel == SEL_FLUSH);
  assign clr_int   = wr & (sel == SEL_CLR_INT);

endmodule

// ==== hw/sdmac_registers.sv ====
// CPU-visible registers and control flags, all on ACR_WR
// Read data is registered: rvalid one cycle after the strobe, value as of the strobe
`timescale 1ns/10ps
`include "sdmac_config.svh"

module sdmac_registers (
  input  logic                       ACR_WR,
  input  logic                       RST_,
  input  logic [`SDMAC_DATA_W-1:0]   bus_wdata,
  input  logic                       rd_stb,
  input  sdmac_pkg::reg_sel_e        rd_sel,
  input  logic                       cntr_wr,
  input  logic                       acr_wr,
  input  logic                       st_dma,
  input  logic                       sp_dma,
  input  logic                       flush_req,
  input  logic                       clr_int,
  input  logic                       dev_int,     // Device interrupt pulse
  input  logic                       fifo_empty,
  input  logic                       fifo_full,
  input  logic                       fifo_ovr,    // Dropped push pulse
  input  logic                       flush_done,  // FIFO finished flushing
  output logic [`SDMAC_DATA_W-1:0]   bus_rdata,
  output logic                       bus_rvalid,
  output logic                       dma_ena,
  output logic                       flush_fifo,
  output logic                       a1,
  output logic                       irq
);

  import sdmac_pkg::*;

  localparam int DW = `SDMAC_DATA_W;
  localparam int CW = `SDMAC_CNTR_W;

  logic [CW-1:0] cntr;     // Control register
  logic          e_int;    // Latched device interrupt
  logic          ovr;      // Latched FIFO overrun
  logic          int_p;
  istr_t         istr;
  logic [DW-1:0] rd_mux;

  // CNTR and A1 load straight from write data
  always_ff @(posedge ACR_WR or negedge RST_) begin
    if (!RST_) begin
      cntr <= '0;
      a1   <= 1'b0;
    end else begin
      if (cntr_wr)
        cntr <= bus_wdata[CW-1:0];         // Upper bits dropped
      if (acr_wr)
        a1 <= bus_wdata[`SDMAC_ACR_A1_BIT];
    end
  end

  // DMA enable, stop beats start
  always_ff @(posedge ACR_WR or negedge RST_) begin
    if (!RST_)
      dma_ena <= 1'b0;
    else if (sp_dma)
      dma_ena <= 1'b0;
    else if (st_dma)
      dma_ena <= 1'b1;
  end

  // Flush flag; drops after the FIFO reports done
  always_ff @(posedge ACR_WR or negedge RST_) begin
    if (!RST_)
      flush_fifo <= 1'b0;
    else if (flush_req)
      flush_fifo <= 1'b1;
    else if (flush_done)
      flush_fifo <= 1'b0;    // Stop-flush
  end

  // Latched status, set wins over clear
  always_ff @(posedge ACR_WR or negedge RST_) begin
    if (!RST_) begin
      e_int <= 1'b0;
      ovr   <= 1'b0;
    end else begin
      if (dev_int)
        e_int <= 1'b1;
      else if (clr_int)
        e_int <= 1'b0;
      if (fifo_ovr)
        ovr <= 1'b1;
      else if (clr_int)
        ovr <= 1'b0;
    end
  end

  assign int_p = e_int & cntr[`SDMAC_CNTR_INTEN];

  // irq follows INT_P one cycle later
  always_ff @(posedge ACR_WR or negedge RST_) begin
    if (!RST_)
      irq <= 1'b0;
    else
      irq <= int_p;
  end

  // ISTR view, FE/FF live at the read cycle
  always_comb begin
    istr       = '0;
    istr.fe    = fifo_empty;
    istr.ff    = fifo_full;
    istr.e_int = e_int;
    istr.ovr   = ovr;
    istr.int_p = int_p;
  end

  // WTC, DAWR, actions and unmapped read zero
  always_comb begin
    case (rd_sel)
      SEL_CNTR: rd_mux = {{(DW-CW){1'b0}}, cntr};
      SEL_ISTR: rd_mux = {{(DW-$bits(istr_t)){1'b0}}, istr};
      default:  rd_mux = '0;
    endcase
  end

  always_ff @(posedge ACR_WR or negedge RST_) begin
    if (!RST_)
      bus_rvalid <= 1'b0;
    else
      bus_rvalid <= rd_stb;  // Exactly one cycle per read
  end

  // Read payload, only meaningful with rvalid
  always_ff @(posedge ACR_WR) begin
    if (rd_stb)
      bus_rdata <= rd_mux;
  end

endmodule

// ==== hw/sdmac_fifo.sv ====
// Circular word FIFO between the peripheral and memory sides
// No back-pressure: pushes while full or flushing are dropped
`timescale 1ns/10ps
`include "sdmac_config.svh"

module sdmac_fifo (
  input  logic                     ACR_WR,
  input  logic                     RST_,
  input  logic                     dev_push,
  input  logic [`SDMAC_DATA_W-1:0] dev_data,
  input  logic                     dma_ena,
  input  logic                     flush_fifo,
  output logic                     mem_valid,   // Registered, cycle after pop
  output logic [`SDMAC_DATA_W-1:0] mem_data,
  output logic                     fifo_empty,
  output logic                     fifo_full,
  output logic                     fifo_ovr,    // Same-cycle pulse on a drop
  output logic                     flush_done
);

  localparam int DEPTH = `SDMAC_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);

  logic [`SDMAC_DATA_W-1:0] mem [DEPTH];
  logic [AW-1:0]            wr_ptr;
  logic [AW-1:0]            rd_ptr;
  logic [AW:0]              count;     // One extra bit for full
  logic                     pop;
  logic                     push_ok;

  assign fifo_empty = (count == '0);
  assign fifo_full  = (count == (AW+1)'(DEPTH));

  // Pop whenever DMA runs and words are waiting
  assign pop     = dma_ena & ~flush_fifo & ~fifo_empty;
  // Full is fine if a word leaves this cycle
  assign push_ok = dev_push & ~flush_fifo & (~fifo_full | pop);
  // Flush drops are silent
  assign fifo_ovr = dev_push & ~flush_fifo & fifo_full & ~pop;

  // Storage, no reset
  always_ff @(posedge ACR_WR) begin
    if (push_ok)
      mem[wr_ptr] <= dev_data;
  end

  always_ff @(posedge ACR_WR or negedge RST_) begin
    if (!RST_) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush_fifo) begin
      wr_ptr <= '0;                  // Discard everything
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok)
        wr_ptr <= wr_ptr + 1'b1;     // Wraps, depth is 2^AW
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push_ok, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;     // Both or neither
      endcase
    end
  end

  // Done pulses once in the second flush cycle
  always_ff @(posedge ACR_WR or negedge RST_) begin
    if (!RST_) begin
      flush_done <= 1'b0;
      mem_valid  <= 1'b0;
    end else begin
      flush_done <= flush_fifo & ~flush_done;
      mem_valid  <= pop;
    end
  end

  // Memory-side word, qualified by mem_valid
  always_ff @(posedge ACR_WR) begin
    if (pop)
      mem_data <= mem[rd_ptr];
  end

endmodule

// ==== hw/sdmac_top.sv ====
// Register subsystem top: decoder, registers and data FIFO
// Single-cycle synchronous bus strobes stand in for the 68030 cycle
`timescale 1ns/10ps
`include "sdmac_config.svh"

module sdmac_top (
  input  logic                     ACR_WR,
  input  logic                     RST_,
  input  logic                     bus_stb,
  input  logic                     bus_rw,      // 1 = read
  input  logic [7:0]               bus_addr,
  input  logic [`SDMAC_DATA_W-1:0] bus_wdata,
  output logic [`SDMAC_DATA_W-1:0] bus_rdata,
  output logic                     bus_rvalid,
  input  logic                     dev_push,
  input  logic [`SDMAC_DATA_W-1:0] dev_data,
  input  logic                     dev_int,
  output logic                     mem_valid,
  output logic [`SDMAC_DATA_W-1:0] mem_data,
  output logic                     dma_ena,
  output logic                     flush_fifo,
  output logic                     a1,
  output logic                     irq
);

  import sdmac_pkg::*;

  // Decoder strobes
  logic     rd_stb;
  reg_sel_e rd_sel;
  logic     cntr_wr;
  logic     acr_wr;
  logic     st_dma;
  logic     sp_dma;
  logic     flush_req;
  logic     clr_int;

  // FIFO status back to the registers
  logic     fifo_empty;
  logic     fifo_full;
  logic     fifo_ovr;
  logic     flush_done;

  sdmac_addr_decoder u_decoder (
    .bus_stb   (bus_stb),
    .bus_rw    (bus_rw),
    .bus_addr  (bus_addr),
    .rd_stb    (rd_stb),
    .rd_sel    (rd_sel),
    .cntr_wr   (cntr_wr),
    .acr_wr    (acr_wr),
    .st_dma    (st_dma),
    .sp_dma    (sp_dma),
    .flush_req (flush_req),
    .clr_int   (clr_int)
  );

  sdmac_registers u_regs (
    .ACR_WR     (ACR_WR),
    .RST_       (RST_),
    .bus_wdata  (bus_wdata),
    .rd_stb     (rd_stb),
    .rd_sel     (rd_sel),
    .cntr_wr    (cntr_wr),
    .acr_wr     (acr_wr),
    .st_dma     (st_dma),
    .sp_dma     (sp_dma),
    .flush_req  (flush_req),
    .clr_int    (clr_int),
    .dev_int    (dev_int),
    .fifo_empty (fifo_empty),
    .fifo_full  (fifo_full),
    .fifo_ovr   (fifo_ovr),
    .flush_done (flush_done),
    .bus_rdata  (bus_rdata),
    .bus_rvalid (bus_rvalid),
    .dma_ena    (dma_ena),
    .flush_fifo (flush_fifo),
    .a1         (a1),
    .irq        (irq)
  );

  sdmac_fifo u_fifo (
    .ACR_WR     (ACR_WR),
    .RST_       (RST_),
    .dev_push   (dev_push),
    .dev_data   (dev_data),
    .dma_ena    (dma_ena),      // Also a top output
    .flush_fifo (flush_fifo),   // Also a top output
    .mem_valid  (mem_valid),
    .mem_data   (mem_data),
    .fifo_empty (fifo_empty),
    .fifo_full  (fifo_full),
    .fifo_ovr   (fifo_ovr),
    .flush_done (flush_done)
  );

endmodule

// ==== sim/sdmac_clk_gen.sv ====
// Free-running 100 ns clock for the testbench
// Reset held low for the first 5 rising edges, then released on an edge
`timescale 1ns/10ps

module sdmac_clk_gen (
  output logic ACR_WR,
  output logic RST_
);

  initial begin
    ACR_WR = 1'b0;
    forever #50 ACR_WR = ~ACR_WR;  // Half period
  end

  initial begin
    RST_ = 1'b0;
    repeat (5) @(posedge ACR_WR);
    RST_ <= 1'b1;
  end

endmodule

// ==== sim/sdmac_tb.sv ====
// Replays sim/sdmac_stimulus.txt against sdmac_top, run from the project root
// Stops at the first mismatch; dma_ena, a1, flush_fifo and irq follow a local model
`timescale 1ns/10ps
`include "sdmac_config.svh"

module sdmac_tb;

  localparam int DW = `SDMAC_DATA_W;

  logic          ACR_WR;
  logic          RST_;
  logic          bus_stb;
  logic          bus_rw;
  logic [7:0]    bus_addr;
  logic [DW-1:0] bus_wdata;
  logic [DW-1:0] bus_rdata;
  logic          bus_rvalid;
  logic          dev_push;
  logic [DW-1:0] dev_data;
  logic          dev_int;
  logic          mem_valid;
  logic [DW-1:0] mem_data;
  logic          dma_ena;
  logic          flush_fifo;
  logic          a1;
  logic          irq;

  // Expected flag state
  logic exp_dma;
  logic exp_a1;
  logic exp_inten;   // CNTR interrupt enable
  logic exp_eint;    // Latched device interrupt

  logic [DW-1:0] mem_q[$];  // Memory-side words not yet matched

  sdmac_clk_gen clk_gen_i (
    .ACR_WR (ACR_WR),
    .RST_   (RST_)
  );

  sdmac_top dut_i (
    .ACR_WR     (ACR_WR),
    .RST_       (RST_),
    .bus_stb    (bus_stb),
    .bus_rw     (bus_rw),
    .bus_addr   (bus_addr),
    .bus_wdata  (bus_wdata),
    .bus_rdata  (bus_rdata),
    .bus_rvalid (bus_rvalid),
    .dev_push   (dev_push),
    .dev_data   (dev_data),
    .dev_int    (dev_int),
    .mem_valid  (mem_valid),
    .mem_data   (mem_data),
    .dma_ena    (dma_ena),
    .flush_fifo (flush_fifo),
    .a1         (a1),
    .irq        (irq)
  );

  // Capture words mid-cycle, where mem_data is stable
  always @(negedge ACR_WR) begin
    if (RST_ && mem_valid)
      mem_q.push_back(mem_data);
  end

  task automatic stop_run();
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic value_error(input string name, input logic [DW-1:0] got,
                             input logic [DW-1:0] exp);
    $display("** Error at %0t ns: %s is 0x%h, expected 0x%h", $time, name, got, exp);
    stop_run();
  endtask

  task automatic run_error(input string what);
    $display("Error at %0t ns: %s", $time, what);
    stop_run();
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got === exp) else value_error(name, DW'(got), DW'(exp));
  endtask

  // Single-cycle write, then flag checks at N+1 and N+2 (N+3 for a flush)
  task automatic bus_write(input logic [7:0] addr, input logic [DW-1:0] data);
    logic is_flush;
    is_flush = (addr == `SDMAC_REG_FLUSH);
    @(posedge ACR_WR);
    bus_stb   <= 1'b1;
    bus_rw    <= 1'b0;
    bus_addr  <= addr;
    bus_wdata <= data;
    @(posedge ACR_WR);
    bus_stb <= 1'b0;
    case (addr)
      `SDMAC_REG_CNTR:    exp_inten = data[`SDMAC_CNTR_INTEN];
      `SDMAC_REG_ACR:     exp_a1 = data[`SDMAC_ACR_A1_BIT];
      `SDMAC_REG_ST_DMA:  exp_dma = 1'b1;
      `SDMAC_REG_SP_DMA:  exp_dma = 1'b0;
      `SDMAC_REG_CLR_INT: exp_eint = 1'b0;
      default:            ;   // DAWR and others change no flag
    endcase
    @(negedge ACR_WR);                       // Cycle N+1
    check_bit("dma_ena", dma_ena, exp_dma);
    check_bit("a1", a1, exp_a1);
    check_bit("flush_fifo", flush_fifo, is_flush);
    @(negedge ACR_WR);                       // Cycle N+2, irq lags one more
    check_bit("flush_fifo", flush_fifo, is_flush);
    check_bit("irq", irq, exp_eint & exp_inten);
    if (is_flush) begin
      @(negedge ACR_WR);                     // Flush flag high for 2 cycles only
      check_bit("flush_fifo", flush_fifo, 1'b0);
    end
  endtask

  task automatic bus_read(input logic [7:0] addr, input logic [DW-1:0] exp);
    int n;
    @(posedge ACR_WR);
    bus_stb  <= 1'b1;
    bus_rw   <= 1'b1;
    bus_addr <= addr;
    @(posedge ACR_WR);
    bus_stb <= 1'b0;
    n = 0;
    @(negedge ACR_WR);
    while (!bus_rvalid && n < 4) begin
      @(negedge ACR_WR);
      n++;
    end
    assert (bus_rvalid) else run_error($sformatf("no bus_rvalid for read of 0x%h", addr));
    assert (bus_rdata === exp) else value_error("bus_rdata", bus_rdata, exp);
  endtask

  task automatic dev_write(input logic [DW-1:0] data);
    @(posedge ACR_WR);
    dev_push <= 1'b1;
    dev_data <= data;
    @(posedge ACR_WR);
    dev_push <= 1'b0;
  endtask

  task automatic dev_interrupt();
    @(posedge ACR_WR);
    dev_int <= 1'b1;
    @(posedge ACR_WR);
    dev_int <= 1'b0;
    exp_eint = 1'b1;
    @(negedge ACR_WR);
    @(negedge ACR_WR);                       // E_INT then irq
    check_bit("irq", irq, exp_eint & exp_inten);
  endtask

  task automatic mem_expect(input logic [DW-1:0] exp);
    int            n;
    logic [DW-1:0] got;
    n = 0;
    while (mem_q.size() == 0 && n < 20) begin
      @(posedge ACR_WR);                     // Monitor fills on negedge
      n++;
    end
    assert (mem_q.size() != 0)
      else run_error($sformatf("no memory word within 20 cycles, expected 0x%h", exp));
    got = mem_q.pop_front();
    assert (got === exp) else value_error("mem_data", got, exp);
  endtask

  initial begin
    int            fd;
    int            n;
    int            wait_n;
    string         line;
    logic [7:0]    op;
    logic [DW-1:0] arg_a;
    logic [DW-1:0] arg_b;
    bus_stb   = 1'b0;
    bus_rw    = 1'b0;
    bus_addr  = '0;
    bus_wdata = '0;
    dev_push  = 1'b0;
    dev_data  = '0;
    dev_int   = 1'b0;
    exp_dma   = 1'b0;
    exp_a1    = 1'b0;
    exp_inten = 1'b0;
    exp_eint  = 1'b0;
    wait_n    = 0;
    while (RST_ !== 1'b1 && wait_n < 20) begin
      @(posedge ACR_WR);
      wait_n++;
    end
    assert (RST_ === 1'b1) else run_error("reset was never released");
    @(negedge ACR_WR);
    // Everything quiet out of reset
    check_bit("dma_ena", dma_ena, 1'b0);
    check_bit("flush_fifo", flush_fifo, 1'b0);
    check_bit("a1", a1, 1'b0);
    check_bit("irq", irq, 1'b0);
    check_bit("bus_rvalid", bus_rvalid, 1'b0);
    check_bit("mem_valid", mem_valid, 1'b0);
    fd = $fopen("sim/sdmac_stimulus.txt", "r");
    assert (fd != 0) else run_error("cannot open sim/sdmac_stimulus.txt");
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n <= 1 || line.getc(0) == "#")
        continue;                            // Blank or comment
      n = $sscanf(line, "%c %h %h", op, arg_a, arg_b);
      case (op)
        "W": bus_write(arg_a[7:0], arg_b);
        "R": bus_read(arg_a[7:0], arg_b);
        "P": dev_write(arg_a);
        "M": mem_expect(arg_a);
        "I": dev_interrupt();
        "D": repeat (arg_a) @(posedge ACR_WR);
        default: run_error($sformatf("unknown stimulus line: %s", line));
      endcase
    end
    $fclose(fd);
    repeat (4) @(posedge ACR_WR);            // Let any stray word show up
    assert (mem_q.size() == 0)
      else run_error($sformatf("%0d memory words were never expected", mem_q.size()));
    $display("TEST OK");
    $finish;
  end

endmodule

// ==== sim/sdmac_stimulus.txt ====
# op  arg1      arg2     all hex; W addr data | R addr expected | P data
# M expected | I (device interrupt) | D idle cycles
# Reset values and zero reads
R 1c 00000001
R 08 00000000
R 04 00000000
R 00 00000000
R 80 00000000
W 00 12345678
R 00 00000000
# CNTR keeps 6 bits, ACR keeps bit 25
W 08 ffffffc3
R 08 00000003
W 0c 02000000
W 0c fdffffff
# Five words wait with DMA off, then stream in order
P 11110001
P 22220002
P 33330003
P 44440004
P 55550005
R 1c 00000000
W 10 00000000
M 11110001
M 22220002
M 33330003
M 44440004
M 55550005
R 1c 00000001
# Stopped DMA holds new words
W 3c 00000000
P 66660006
P 77770007
D 05
R 1c 00000000
W 10 00000000
M 66660006
M 77770007
R 1c 00000001
# Fill plus one drop
W 3c 00000000
P a0000001
P a0000002
P a0000003
P a0000004
P a0000005
P a0000006
P a0000007
P a0000008
P a0000009
R 1c 0000000a
W 18 00000000
R 1c 00000002
# Flush discards the full FIFO
W 14 00000000
R 1c 00000001
W 10 00000000
D 0a
P 0000abcd
M 0000abcd
W 3c 00000000
# Interrupt path
I
R 1c 00000005
W 08 00000004
R 1c 00000015
R 08 00000004
W 18 00000000
R 1c 00000001

// ==== vlog.f ====
+incdir+hw
hw/sdmac_pkg.sv
hw/sdmac_addr_decoder.sv
hw/sdmac_registers.sv
hw/sdmac_fifo.sv
hw/sdmac_top.sv
sim/sdmac_clk_gen.sv
sim/sdmac_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator from the project root

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "Cannot enter the project root"
  exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f --top-module sdmac_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vsdmac_tb 2>&1)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "^TEST OK$"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
